/* design/regbank_pkg.sv */
package regbank_pkg;

	// register map sizes
	localparam int NUM_REGS = 4;
	localparam int NUM_IRQ = 3;
	localparam int ADDR_WIDTH = 5;
	localparam int IDX_WIDTH = 3;

	// bit i set means register i is software writable
	localparam logic [NUM_REGS-1:0] ALLOW_WRITE = 4'b0111;

	// word index of the interrupt status word
	localparam logic [IDX_WIDTH-1:0] IRQ_IDX = IDX_WIDTH'(NUM_REGS);

	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	typedef struct packed {
		logic [ADDR_WIDTH-1:0] awaddr;
		logic [2:0] awprot;
		logic awvalid;
		logic [31:0] wdata;
		logic [3:0] wstrb;
		logic wvalid;
		logic bready;
		logic [ADDR_WIDTH-1:0] araddr;
		logic [2:0] arprot;
		logic arvalid;
		logic rready;
	} axil_req_t;

	typedef struct packed {
		logic awready;
		logic wready;
		logic [1:0] bresp;
		logic bvalid;
		logic arready;
		logic [31:0] rdata;
		logic [1:0] rresp;
		logic rvalid;
	} axil_rsp_t;

	// single-cycle write command toward the bank
	typedef struct packed {
		logic valid;
		logic [IDX_WIDTH-1:0] index;
		logic [31:0] data;
		logic [3:0] strb;
	} reg_write_t;

	typedef logic [NUM_REGS-1:0][31:0] reg_file_t;

endpackage

/* design/axil_slave.sv */
`timescale 1ns/10ps

module axil_slave (
	input logic clk,
	input logic arst_n,
	input regbank_pkg::axil_req_t s_axil_req,
	output regbank_pkg::axil_rsp_t s_axil_rsp,
	input logic [regbank_pkg::NUM_REGS:0][31:0] read_words,
	output regbank_pkg::reg_write_t reg_wr
);
	import regbank_pkg::*;

	logic ready_en;

	logic awready;
	logic wready;
	logic arready;

	logic aw_fire;
	logic w_fire;
	logic ar_fire;

	logic aw_held;
	logic w_held;
	logic [IDX_WIDTH-1:0] aw_idx;
	logic [31:0] w_data;
	logic [3:0] w_strb;
	logic wr_cmd;

	logic bvalid;
	logic [1:0] bresp;

	logic [IDX_WIDTH-1:0] ar_idx;
	logic [31:0] rd_word;
	logic [1:0] rd_resp;
	logic rvalid;
	logic [31:0] rdata;
	logic [1:0] rresp;

	// readies stay low for one cycle after reset release
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ready_en <= 1'b0;
		end else begin
			ready_en <= 1'b1;
		end
	end

	assign awready = ready_en && !aw_held && !bvalid;
	assign wready = ready_en && !w_held && !bvalid;
	assign arready = ready_en && !rvalid;

	assign aw_fire = s_axil_req.awvalid && awready;
	assign w_fire = s_axil_req.wvalid && wready;
	assign ar_fire = s_axil_req.arvalid && arready;

	// address and data may land in either order
	assign wr_cmd = aw_held && w_held;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			aw_held <= 1'b0;
			w_held <= 1'b0;
		end else if (wr_cmd) begin
			aw_held <= 1'b0;
			w_held <= 1'b0;
		end else begin
			if (aw_fire) begin
				aw_held <= 1'b1;
			end
			if (w_fire) begin
				w_held <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (aw_fire) begin
			aw_idx <= s_axil_req.awaddr[ADDR_WIDTH-1:2];
		end
		if (w_fire) begin
			w_data <= s_axil_req.wdata;
			w_strb <= s_axil_req.wstrb;
		end
	end

	assign reg_wr = '{valid: wr_cmd, index: aw_idx, data: w_data, strb: w_strb};

	// write response
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			bvalid <= 1'b0;
		end else if (wr_cmd) begin
			bvalid <= 1'b1;
		end else if (s_axil_req.bready) begin
			bvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_cmd) begin
			bresp <= (aw_idx > IRQ_IDX) ? RESP_SLVERR : RESP_OKAY;
		end
	end

	// read decode treats anything past the status word as unmapped
	assign ar_idx = s_axil_req.araddr[ADDR_WIDTH-1:2];

	always_comb begin
		rd_word = '0;
		rd_resp = RESP_SLVERR;
		if (ar_idx <= IRQ_IDX) begin
			rd_word = read_words[ar_idx];
			rd_resp = RESP_OKAY;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rvalid <= 1'b0;
		end else if (ar_fire) begin
			rvalid <= 1'b1;
		end else if (s_axil_req.rready) begin
			rvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (ar_fire) begin
			rdata <= rd_word;
			rresp <= rd_resp;
		end
	end

	always_comb begin
		s_axil_rsp.awready = awready;
		s_axil_rsp.wready = wready;
		s_axil_rsp.bresp = bresp;
		s_axil_rsp.bvalid = bvalid;
		s_axil_rsp.arready = arready;
		s_axil_rsp.rdata = rdata;
		s_axil_rsp.rresp = rresp;
		s_axil_rsp.rvalid = rvalid;
	end

	bvalid_held: assert property (@(posedge clk) disable iff (!arst_n)
		bvalid && !s_axil_req.bready |=> bvalid && $stable(bresp));

	rdata_stable: assert property (@(posedge clk) disable iff (!arst_n)
		rvalid && !s_axil_req.rready |=> rvalid && $stable(rdata) && $stable(rresp));

	// command is a single pulse per transaction
	wr_cmd_pulse: assert property (@(posedge clk) disable iff (!arst_n)
		reg_wr.valid |=> !reg_wr.valid);

endmodule

/* design/register_bank.sv */
`timescale 1ns/10ps

module register_bank (
	input logic clk,
	input logic arst_n,
	input regbank_pkg::reg_write_t reg_wr,
	input regbank_pkg::reg_file_t reg_in,
	output regbank_pkg::reg_file_t reg_val
);
	import regbank_pkg::*;

	for (genvar i = 0; i < NUM_REGS; i++) begin : g_reg
		logic [31:0] word_q;

		if (ALLOW_WRITE[i]) begin : g_rw
			logic hit;

			assign hit = reg_wr.valid && (reg_wr.index == IDX_WIDTH'(i));

			// byte lanes merge under strobe
			always_ff @(posedge clk or negedge arst_n) begin
				if (!arst_n) begin
					word_q <= '0;
				end else if (hit) begin
					for (int b = 0; b < 4; b++) begin
						if (reg_wr.strb[b]) begin
							word_q[8*b +: 8] <= reg_wr.data[8*b +: 8];
						end
					end
				end
			end
		end else begin : g_ro
			// tracks fabric input every cycle
			always_ff @(posedge clk) begin
				word_q <= reg_in[i];
			end
		end

		assign reg_val[i] = word_q;
	end

endmodule

/* design/reg_bank_intr.sv */
`timescale 1ns/10ps

module reg_bank_intr (
	input logic clk,
	input logic arst_n,
	input regbank_pkg::axil_req_t s_axil_req,
	output regbank_pkg::axil_rsp_t s_axil_rsp,
	input logic [regbank_pkg::NUM_IRQ-1:0] irq,
	output logic ps_irq,
	output logic irq_reset,
	input regbank_pkg::reg_file_t reg_in,
	output regbank_pkg::reg_file_t reg_val
);
	import regbank_pkg::*;

	reg_write_t reg_wr;
	logic [31:0] irq_word;
	logic [NUM_REGS:0][31:0] read_words;

	// status word sits right after the data registers
	assign irq_word = {{(32-NUM_IRQ){1'b0}}, irq};
	assign read_words = {irq_word, reg_val};

	axil_slave u_axil (
		.clk(clk),
		.arst_n(arst_n),
		.s_axil_req(s_axil_req),
		.s_axil_rsp(s_axil_rsp),
		.read_words(read_words),
		.reg_wr(reg_wr)
	);

	register_bank u_bank (
		.clk(clk),
		.arst_n(arst_n),
		.reg_wr(reg_wr),
		.reg_in(reg_in),
		.reg_val(reg_val)
	);

	// ack pulse comes from a write to the status word
	always_comb begin
		irq_reset = reg_wr.valid && (reg_wr.index == IRQ_IDX);
		ps_irq = (|irq) && !irq_reset;
	end

	// ack is followed by the write response
	ack_then_bresp: assert property (@(posedge clk) disable iff (!arst_n)
		irq_reset |=> s_axil_rsp.bvalid && s_axil_rsp.bresp == RESP_OKAY);

endmodule

/* testbench/tb_tests.svh */
task automatic send_aw(input logic [IDX_WIDTH-1:0] idx);
	req.awaddr = {idx, 2'b00};
	req.awvalid = 1'b1;
	wait_flag(F_AWREADY, "awready");
	@(posedge clk);
	#2;
	req.awvalid = 1'b0;
endtask

task automatic send_w(input logic [31:0] data, input logic [3:0] strb);
	req.wdata = data;
	req.wstrb = strb;
	req.wvalid = 1'b1;
	wait_flag(F_WREADY, "wready");
	@(posedge clk);
	#2;
	req.wvalid = 1'b0;
endtask

// order 0 sends address and data together, 1 address first, 2 data first
task automatic axil_write(input logic [IDX_WIDTH-1:0] idx, input logic [31:0] data,
		input logic [3:0] strb, input int order, input int hold, output logic [1:0] resp);
	case (order)
		1: begin
			send_aw(idx);
			send_w(data, strb);
		end
		2: begin
			send_w(data, strb);
			send_aw(idx);
		end
		default: begin
			fork
				send_aw(idx);
				send_w(data, strb);
			join
		end
	endcase
	wait_flag(F_BVALID, "bvalid");
	resp = rsp.bresp;
	for (int c = 0; c < hold; c++) begin
		@(negedge clk);
		check_bit("bvalid", 1'b1, rsp.bvalid);
		check_value("bresp", {30'd0, resp}, {30'd0, rsp.bresp});
		check_bit("awready", 1'b0, rsp.awready);
		check_bit("wready", 1'b0, rsp.wready);
	end
	@(posedge clk);
	#2;
	req.bready = 1'b1;
	@(posedge clk);
	#2;
	req.bready = 1'b0;
endtask

task automatic axil_read(input logic [IDX_WIDTH-1:0] idx, input int hold,
		output logic [31:0] data, output logic [1:0] resp);
	req.araddr = {idx, 2'b00};
	req.arvalid = 1'b1;
	wait_flag(F_ARREADY, "arready");
	@(posedge clk);
	#2;
	req.arvalid = 1'b0;
	wait_flag(F_RVALID, "rvalid");
	data = rsp.rdata;
	resp = rsp.rresp;
	for (int c = 0; c < hold; c++) begin
		@(negedge clk);
		check_bit("rvalid", 1'b1, rsp.rvalid);
		check_value("rdata", data, rsp.rdata);
		check_bit("arready", 1'b0, rsp.arready);
	end
	@(posedge clk);
	#2;
	req.rready = 1'b1;
	@(posedge clk);
	#2;
	req.rready = 1'b0;
endtask

task automatic read_expect(input logic [IDX_WIDTH-1:0] idx, input int hold,
		input logic [31:0] exp_data, input logic [1:0] exp_resp);
	logic [31:0] data;
	logic [1:0] resp;
	axil_read(idx, hold, data, resp);
	check_value("rdata", exp_data, data);
	check_value("rresp", {30'd0, exp_resp}, {30'd0, resp});
endtask

task automatic write_expect(input logic [IDX_WIDTH-1:0] idx, input logic [31:0] data,
		input logic [3:0] strb, input int order, input int hold, input logic [1:0] exp_resp);
	logic [1:0] resp;
	axil_write(idx, data, strb, order, hold, resp);
	check_value("bresp", {30'd0, exp_resp}, {30'd0, resp});
endtask

function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
		input logic [3:0] strb);
	logic [31:0] mask;
	mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
	return (old & ~mask) | (data & mask);
endfunction

// read-only words follow reg_in, the rest follow the shadow copy
task automatic check_regs();
	for (int i = 0; i < NUM_REGS; i++) begin
		check_value("reg_val", ALLOW_WRITE[i] ? shadow[i] : reg_in[i], reg_val[i]);
	end
endtask

task automatic reset_defaults();
	int errs;
	errs = fail_count;
	@(negedge clk);
	check_bit("bvalid", 1'b0, rsp.bvalid);
	check_bit("rvalid", 1'b0, rsp.rvalid);
	check_bit("irq_reset", 1'b0, irq_reset);
	check_bit("ps_irq", 1'b0, ps_irq);
	@(posedge clk);
	#2;
	for (int i = 0; i < 3; i++) begin
		read_expect(IDX_WIDTH'(i), 0, 32'h0, RESP_OKAY);
	end
	read_expect(3'd3, 0, reg_in[3], RESP_OKAY);
	report_test("reset_defaults", errs);
endtask

task automatic write_readback();
	int errs;
	logic [31:0] data;
	logic [31:0] rnd;
	logic [3:0] strb;
	errs = fail_count;
	// first round full strobes, second round random strobes
	for (int round = 0; round < 2; round++) begin
		for (int i = 0; i < 3; i++) begin
			data = $random(seed);
			rnd = $random(seed);
			strb = (round == 0) ? 4'hf : rnd[3:0];
			shadow[i] = merge_bytes(shadow[i], data, strb);
			write_expect(IDX_WIDTH'(i), data, strb, i, 0, RESP_OKAY);
			check_regs();
			read_expect(IDX_WIDTH'(i), 0, shadow[i], RESP_OKAY);
		end
	end
	report_test("write_readback", errs);
endtask

task automatic read_only_word();
	int errs;
	logic [31:0] data;
	errs = fail_count;
	data = $random(seed);
	write_expect(3'd3, data, 4'hf, 0, 0, RESP_OKAY);
	check_regs();
	read_expect(3'd3, 0, reg_in[3], RESP_OKAY);
	reg_in[3] = $random(seed);
	// read-only word picks up reg_in one edge later
	@(posedge clk);
	#2;
	read_expect(3'd3, 0, reg_in[3], RESP_OKAY);
	check_regs();
	report_test("read_only_word", errs);
endtask

task automatic unmapped_words();
	int errs;
	logic [31:0] data;
	errs = fail_count;
	for (int i = 5; i < 8; i++) begin
		data = $random(seed);
		write_expect(IDX_WIDTH'(i), data, 4'hf, 0, 0, RESP_SLVERR);
		check_regs();
		read_expect(IDX_WIDTH'(i), 0, 32'h0, RESP_SLVERR);
	end
	report_test("unmapped_words", errs);
endtask

task automatic irq_ack();
	int errs;
	int pulses;
	logic prev_ack;
	errs = fail_count;
	irq = 3'b101;
	@(negedge clk);
	check_bit("ps_irq", 1'b1, ps_irq);
	@(posedge clk);
	#2;
	read_expect(IRQ_IDX, 0, 32'(irq), RESP_OKAY);
	pulses = 0;
	prev_ack = 1'b0;
	fork
		write_expect(IRQ_IDX, 32'hffff_ffff, 4'hf, 0, 0, RESP_OKAY);
		begin
			for (int c = 0; c < 12; c++) begin
				@(negedge clk);
				// bvalid must follow the ack cycle directly
				if (prev_ack) begin
					check_bit("bvalid", 1'b1, rsp.bvalid);
				end
				prev_ack = irq_reset;
				if (irq_reset) begin
					pulses++;
					check_bit("ps_irq", 1'b0, ps_irq);
					check_bit("bvalid", 1'b0, rsp.bvalid);
				end
			end
		end
	join
	check_value("irq_reset pulse count", 32'd1, 32'(pulses));
	check_bit("ps_irq", 1'b1, ps_irq);
	@(posedge clk);
	#2;
	irq = '0;
	@(negedge clk);
	check_bit("ps_irq", 1'b0, ps_irq);
	@(posedge clk);
	#2;
	check_regs();
	report_test("irq_ack", errs);
endtask

task automatic bus_back_pressure();
	int errs;
	logic [31:0] data;
	errs = fail_count;
	data = $random(seed);
	shadow[1] = data;
	write_expect(3'd1, data, 4'hf, 1, 4, RESP_OKAY);
	data = $random(seed);
	shadow[2] = data;
	write_expect(3'd2, data, 4'hf, 2, 4, RESP_OKAY);
	check_regs();
	read_expect(3'd1, 4, shadow[1], RESP_OKAY);
	read_expect(3'd2, 4, shadow[2], RESP_OKAY);
	report_test("bus_back_pressure", errs);
endtask

/* testbench/tb_reg_bank_intr.sv */
`timescale 1ns/10ps

module tb_reg_bank_intr;
	import regbank_pkg::*;

	localparam int TIMEOUT = 40;
	// codes for the response flags that wait_flag can watch
	localparam int F_AWREADY = 0;
	localparam int F_WREADY = 1;
	localparam int F_ARREADY = 2;
	localparam int F_BVALID = 3;
	localparam int F_RVALID = 4;

	logic clk = 1'b0;
	logic arst_n;
	axil_req_t req;
	axil_rsp_t rsp;
	logic [NUM_IRQ-1:0] irq;
	logic ps_irq;
	logic irq_reset;
	reg_file_t reg_in;
	reg_file_t reg_val;

	// expected contents of the writable registers
	reg_file_t shadow;
	integer seed = 32'h424e;
	int pass_count = 0;
	int fail_count = 0;

	always #10 clk = ~clk;

	reg_bank_intr DUT (
		.clk(clk),
		.arst_n(arst_n),
		.s_axil_req(req),
		.s_axil_rsp(rsp),
		.irq(irq),
		.ps_irq(ps_irq),
		.irq_reset(irq_reset),
		.reg_in(reg_in),
		.reg_val(reg_val)
	);

	task automatic check_value(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		assert (act === exp) pass_count++;
		else begin
			$display("ERROR %s: expected %h, actual %h", name, exp, act);
			fail_count++;
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		check_value(name, {31'd0, exp}, {31'd0, act});
	endtask

	function automatic logic flag_value(input int which);
		case (which)
			F_AWREADY: return rsp.awready;
			F_WREADY: return rsp.wready;
			F_ARREADY: return rsp.arready;
			F_BVALID: return rsp.bvalid;
			default: return rsp.rvalid;
		endcase
	endfunction

	// returns on the falling edge where the flag is seen high
	task automatic wait_flag(input int which, input string what);
		int n;
		n = 0;
		@(negedge clk);
		while (!flag_value(which) && n < TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		assert (flag_value(which))
		else begin
			$display("timeout: %s never went high", what);
			fail_count++;
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		if (fail_count == errs_before) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d failures", name, fail_count - errs_before);
		end
	endtask

	`include "tb_tests.svh"

	initial begin
		arst_n = 1'b0;
		req = '0;
		irq = '0;
		reg_in = '0;
		reg_in[3] = 32'h3c0f_a503;
		shadow = '0;
		repeat (8) @(posedge clk);
		#2;
		arst_n = 1'b1;
		reset_defaults();
		write_readback();
		read_only_word();
		unmapped_words();
		irq_ack();
		bus_back_pressure();
		$display("checks passed: %0d, failed: %0d", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

/* build.f */
+incdir+testbench
design/regbank_pkg.sv
design/axil_slave.sv
design/register_bank.sv
design/reg_bank_intr.sv
testbench/tb_reg_bank_intr.sv

/* run_sim.sh */
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module tb_reg_bank_intr \
	-Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulator exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "Simulation passed"; then
	exit 0
fi
exit 1
